// File: Bender.yml
package:
  name: vig

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/vig_pkg.sv
      - hw/vig_host_regs.sv
      - hw/vig_col_gain.sv
      - hw/vig_row_gain.sv
      - hw/vig_scale.sv
      - hw/vig_top.sv
      - target: simulation
        files:
          - sim/vig_tb.sv

// File: filelist.f
+incdir+include
hw/vig_pkg.sv
hw/vig_host_regs.sv
hw/vig_col_gain.sv
hw/vig_row_gain.sv
hw/vig_scale.sv
hw/vig_top.sv
sim/vig_tb.sv

// File: hw/vig_col_gain.sv
`timescale 1ns/1ps
`include "vig_defs.svh"

module vig_col_gain (
   input  logic                      clk,
   input  logic                      resetb,
   input  vig_pkg::pix_beat_t        beat,
   input  logic                      tbl_we,
   input  logic [`VIG_COL_IDX_W-1:0] tbl_idx,
   input  vig_pkg::gain_t            tbl_wdat,
   output vig_pkg::gain_t            tbl_rdat,
   output vig_pkg::gain_t            gain
);

   // One spare bit so the position can sit one past the last column
   localparam int              POS_W   = `VIG_COL_IDX_W + 1;
   localparam logic [POS_W-1:0] POS_MAX = POS_W'(`VIG_NUM_COLS);

   vig_pkg::gain_t   col_tbl [`VIG_NUM_COLS];
   logic [POS_W-1:0] col_pos;
   logic             is_pixel;
   logic             is_row_start;

   assign is_pixel     = beat.valid && (beat.btype == vig_pkg::BT_PIXEL);
   assign is_row_start = beat.valid && (beat.btype == vig_pkg::BT_ROW_START);

   // Gain table, every entry back to 1.0 on reset
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         for (int i = 0; i < `VIG_NUM_COLS; i++) begin
            col_tbl[i] <= vig_pkg::gain_t'(`VIG_GAIN_ONE);
         end
      end else if (tbl_we) begin
         col_tbl[tbl_idx] <= tbl_wdat;
      end
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         col_pos <= '0;
      end else if (is_row_start) begin
         col_pos <= '0;
      end else if (is_pixel) begin
         col_pos <= col_pos + 1'b1;
      end
   end

   // Stream port looks up the position before it advances
   always_ff @(posedge clk) begin
      gain     <= col_tbl[col_pos[`VIG_COL_IDX_W-1:0]];
      tbl_rdat <= col_tbl[tbl_idx];   // Host read port
   end

   // A row longer than the table would wrap onto column 0
   a_col_in_range: assert property (
      @(posedge clk) disable iff (!resetb)
      is_pixel |-> (col_pos != POS_MAX)
   ) else $error("pixel beyond last column");

endmodule

// File: hw/vig_host_regs.sv
`timescale 1ns/1ps
`include "vig_defs.svh"

module vig_host_regs (
   input  logic                      clk,
   input  logic                      resetb,
   input  vig_pkg::wb_req_t          wb_req,
   output vig_pkg::wb_rsp_t          wb_rsp,
   output logic                      col_we,
   output logic                      row_we,
   output logic [`VIG_COL_IDX_W-1:0] tbl_idx,
   output vig_pkg::gain_t            tbl_wdat,
   input  vig_pkg::gain_t            col_rdat,
   input  vig_pkg::gain_t            row_rdat
);

   logic           req_new;
   logic           ack_q;
   logic           row_sel_q;   // Table targeted by the access being acked
   vig_pkg::gain_t sel_rdat;

   // A held request is acked once, then the slave waits for the next one
   assign req_new = wb_req.cyc && wb_req.stb && !ack_q;

   assign col_we   = req_new && wb_req.we && !wb_req.adr[`VIG_ADR_ROW_BIT];
   assign row_we   = req_new && wb_req.we &&  wb_req.adr[`VIG_ADR_ROW_BIT];
   assign tbl_idx  = wb_req.adr[`VIG_COL_IDX_W-1:0];
   assign tbl_wdat = wb_req.dat[`VIG_GAIN_W-1:0];

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         ack_q     <= 1'b0;
         row_sel_q <= 1'b0;
      end else begin
         ack_q <= req_new;
         if (req_new) begin
            row_sel_q <= wb_req.adr[`VIG_ADR_ROW_BIT];
         end
      end
   end

   // Gain modules return read data on the same edge that raises ack
   assign sel_rdat = row_sel_q ? row_rdat : col_rdat;

   assign wb_rsp.ack = ack_q;
   assign wb_rsp.dat = ack_q ? {{(`VIG_WB_DAT_W-`VIG_GAIN_W){1'b0}}, sel_rdat}
                             : '0;

   // Master must hold cyc and stb until it sees ack
   a_ack_in_cycle: assert property (
      @(posedge clk) disable iff (!resetb)
      wb_rsp.ack |-> (wb_req.cyc && wb_req.stb)
   ) else $error("ack outside an active bus cycle");

endmodule

// File: hw/vig_pkg.sv
`include "vig_defs.svh"

package vig_pkg;

   // Stream beat tag
   typedef enum logic [2:0] {
      BT_FRAME_START = 3'd0,
      BT_FRAME_END   = 3'd1,
      BT_ROW_START   = 3'd2,
      BT_ROW_END     = 3'd3,
      BT_PIXEL       = 3'd4,
      BT_AUX         = 3'd5
   } beat_type_e;

   typedef struct packed {
      logic                   valid;
      beat_type_e             btype;
      logic [`VIG_DATA_W-1:0] data;   // Pixel in the low byte
   } pix_beat_t;

   typedef logic [`VIG_GAIN_W-1:0] gain_t;

   // Host to slave
   typedef struct packed {
      logic                     cyc;
      logic                     stb;
      logic                     we;
      logic [`VIG_WB_ADR_W-1:0] adr;
      logic [`VIG_WB_DAT_W-1:0] dat;
   } wb_req_t;

   // Slave to host
   typedef struct packed {
      logic                     ack;
      logic [`VIG_WB_DAT_W-1:0] dat;
   } wb_rsp_t;

endpackage

// File: hw/vig_row_gain.sv
`timescale 1ns/1ps
`include "vig_defs.svh"

module vig_row_gain (
   input  logic                      clk,
   input  logic                      resetb,
   input  vig_pkg::pix_beat_t        beat,
   input  logic                      tbl_we,
   input  logic [`VIG_ROW_IDX_W-1:0] tbl_idx,
   input  vig_pkg::gain_t            tbl_wdat,
   output vig_pkg::gain_t            tbl_rdat,
   output vig_pkg::gain_t            gain
);

   localparam int TBL_AW = $clog2(`VIG_NUM_ROWS);

   vig_pkg::gain_t            row_tbl [`VIG_NUM_ROWS];
   logic [`VIG_ROW_IDX_W-1:0] row_pos;
   logic                      host_in_range;
   logic                      pos_in_range;
   logic                      is_frame_start;
   logic                      is_row_end;

   assign is_frame_start = beat.valid && (beat.btype == vig_pkg::BT_FRAME_START);
   assign is_row_end     = beat.valid && (beat.btype == vig_pkg::BT_ROW_END);

   // Index space is wider than the table
   assign host_in_range = (tbl_idx < `VIG_NUM_ROWS);
   assign pos_in_range  = (row_pos < `VIG_NUM_ROWS);

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         for (int i = 0; i < `VIG_NUM_ROWS; i++) begin
            row_tbl[i] <= vig_pkg::gain_t'(`VIG_GAIN_ONE);
         end
      end else if (tbl_we && host_in_range) begin
         row_tbl[tbl_idx[TBL_AW-1:0]] <= tbl_wdat;
      end
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         row_pos <= '0;
      end else if (is_frame_start) begin
         row_pos <= '0;
      end else if (is_row_end) begin
         row_pos <= row_pos + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      gain     <= pos_in_range ? row_tbl[row_pos[TBL_AW-1:0]] : '0;
      tbl_rdat <= host_in_range ? row_tbl[tbl_idx[TBL_AW-1:0]] : '0;   // Zero past the table
   end

   // Row counter must not wrap within a frame
   a_row_no_wrap: assert property (
      @(posedge clk) disable iff (!resetb)
      is_row_end |-> (row_pos != '1)
   ) else $error("row end with row position at last index");

endmodule

// File: hw/vig_scale.sv
`timescale 1ns/1ps
`include "vig_defs.svh"

module vig_scale (
   input  logic               clk,
   input  logic               resetb,
   input  logic               enable,
   input  vig_pkg::pix_beat_t beat_in,
   input  vig_pkg::gain_t     col_gain,
   input  vig_pkg::gain_t     row_gain,
   output vig_pkg::pix_beat_t beat_out
);

   localparam int PROD0_W = `VIG_GAIN_W + `VIG_PIX_W;
   localparam int PROD_W  = 2 * `VIG_GAIN_W + `VIG_PIX_W;
   localparam int SHIFT   = 2 * `VIG_GAIN_FRAC;       // Two gains, both fractional
   localparam int TOP_BIT = `VIG_PIX_W + SHIFT;       // First bit above the result

   vig_pkg::pix_beat_t    beat_d;     // Aligned with the registered gains
   logic [PROD0_W-1:0]    prod0;
   logic [PROD_W-1:0]     prod1;
   logic                  overflow;
   logic [`VIG_PIX_W-1:0] pix_scaled;
   logic                  do_scale;

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         beat_d <= '0;
      end else begin
         beat_d <= beat_in;
      end
   end

   assign prod0 = col_gain * beat_d.data[`VIG_PIX_W-1:0];
   assign prod1 = row_gain * prod0;

   // Anything above bit 19 saturates the pixel
   assign overflow   = |prod1[PROD_W-1:TOP_BIT];
   assign pix_scaled = overflow ? '1 : prod1[TOP_BIT-1:SHIFT];

   assign do_scale = enable && beat_d.valid && (beat_d.btype == vig_pkg::BT_PIXEL);

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         beat_out <= '0;
      end else begin
         beat_out.valid <= beat_d.valid;
         beat_out.btype <= beat_d.btype;
         if (do_scale) begin
            beat_out.data <= {{(`VIG_DATA_W-`VIG_PIX_W){1'b0}}, pix_scaled};
         end else begin
            beat_out.data <= beat_d.data;   // Markers, aux and bypass
         end
      end
   end

endmodule

// File: hw/vig_top.sv
`timescale 1ns/1ps
`include "vig_defs.svh"

module vig_top (
   input  logic               clk,
   input  logic               resetb,
   input  logic               enable,
   input  vig_pkg::wb_req_t   wb_req,
   output vig_pkg::wb_rsp_t   wb_rsp,
   input  vig_pkg::pix_beat_t beat_in,
   output vig_pkg::pix_beat_t beat_out
);

   logic                      col_we;
   logic                      row_we;
   logic [`VIG_COL_IDX_W-1:0] tbl_idx;
   vig_pkg::gain_t            tbl_wdat;
   vig_pkg::gain_t            col_rdat;
   vig_pkg::gain_t            row_rdat;
   vig_pkg::gain_t            col_gain;
   vig_pkg::gain_t            row_gain;

   vig_host_regs u_host_regs (
      .clk      (clk),
      .resetb   (resetb),
      .wb_req   (wb_req),
      .wb_rsp   (wb_rsp),
      .col_we   (col_we),
      .row_we   (row_we),
      .tbl_idx  (tbl_idx),
      .tbl_wdat (tbl_wdat),
      .col_rdat (col_rdat),
      .row_rdat (row_rdat)
   );

   vig_col_gain u_col_gain (
      .clk      (clk),
      .resetb   (resetb),
      .beat     (beat_in),
      .tbl_we   (col_we),
      .tbl_idx  (tbl_idx),
      .tbl_wdat (tbl_wdat),
      .tbl_rdat (col_rdat),
      .gain     (col_gain)
   );

   vig_row_gain u_row_gain (
      .clk      (clk),
      .resetb   (resetb),
      .beat     (beat_in),
      .tbl_we   (row_we),
      .tbl_idx  (tbl_idx),
      .tbl_wdat (tbl_wdat),
      .tbl_rdat (row_rdat),
      .gain     (row_gain)
   );

   vig_scale u_scale (
      .clk      (clk),
      .resetb   (resetb),
      .enable   (enable),
      .beat_in  (beat_in),
      .col_gain (col_gain),
      .row_gain (row_gain),
      .beat_out (beat_out)
   );

endmodule

// File: include/vig_defs.svh
`ifndef VIG_DEFS_SVH
`define VIG_DEFS_SVH

// Stream and pixel widths
`define VIG_PIX_W       8
`define VIG_DATA_W      16

// Gain format, unsigned 2.6 fixed point
`define VIG_GAIN_W      8
`define VIG_GAIN_FRAC   6
`define VIG_GAIN_ONE    64

// Table depths
`define VIG_NUM_COLS    64
`define VIG_COL_IDX_W   6
`define VIG_NUM_ROWS    32
`define VIG_ROW_IDX_W   6

// Wishbone port and address map
`define VIG_WB_ADR_W    12
`define VIG_WB_DAT_W    32
`define VIG_ADR_ROW_BIT 11   // 0 selects column table, 1 selects row table

`endif

// File: sim/vig_tb.sv
`timescale 1ns/1ps
`include "vig_defs.svh"

module vig_tb;

   localparam int TIMEOUT = 20;   // Cycles allowed for a Wishbone ack

   logic               clk;
   logic               resetb;
   logic               enable;
   vig_pkg::wb_req_t   wb_req;
   vig_pkg::wb_rsp_t   wb_rsp;
   vig_pkg::pix_beat_t beat_in;
   vig_pkg::pix_beat_t beat_out;

   logic [31:0]        seed;
   int                 errors;
   int                 test_errors;   // Error count when the current test began
   int                 tests;
   int                 failed_tests;
   int                 checks;
   logic [7:0]         m_col [`VIG_NUM_COLS];   // Reference copies of the tables
   logic [7:0]         m_row [`VIG_NUM_ROWS];
   int                 col_pos;
   int                 row_pos;
   vig_pkg::pix_beat_t exp_q [$];   // Expected beats still in the pipeline

   vig_top dut (
      .clk(clk), .resetb(resetb), .enable(enable), .wb_req(wb_req),
      .wb_rsp(wb_rsp), .beat_in(beat_in), .beat_out(beat_out)
   );

   always #2 clk = ~clk;

   function automatic logic [31:0] lcg();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic int rnd(int n);
      return (lcg() >> 8) % n;   // Upper LCG bits have the longer period
   endfunction

   function automatic vig_pkg::pix_beat_t make_beat(logic v, vig_pkg::beat_type_e t,
                                                    logic [15:0] d);
      return {v, t, d};
   endfunction

   task automatic check(string name, logic [31:0] got, logic [31:0] exp);
      checks++;
      assert (got == exp) else begin
         $display("ERROR %s: got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic end_test(string name);
      tests++;
      if (errors != test_errors) begin
         failed_tests++;
         $display("test %-18s FAIL, %0d errors", name, errors - test_errors);
      end else begin
         $display("test %-18s PASS", name);
      end
      test_errors = errors;
   endtask

   task automatic wb_access(logic we, logic [11:0] adr, logic [31:0] dat,
                            output logic [31:0] rdat);
      int n;
      @(negedge clk);
      wb_req = {1'b1, 1'b1, we, adr, dat};
      for (n = 1; n <= TIMEOUT; n++) begin
         @(negedge clk);
         if (wb_rsp.ack) break;
      end
      if (!wb_rsp.ack) begin
         $display("Timeout, no Wishbone ack within %0d cycles", TIMEOUT);
         $display("TESTS FAILED");
         $finish;
      end else begin
         check("wb_rsp.ack latency", n, 1);
         rdat = wb_rsp.dat;
         @(negedge clk);   // Request held over the edge that samples ack
         check("wb_rsp.ack", wb_rsp.ack, 0);   // Ack lasts one cycle
         wb_req = '0;
      end
   endtask

   task automatic write_gain(logic row, int idx, logic [7:0] g);
      logic [31:0] d;
      wb_access(1'b1, 12'(idx) | (12'(row) << `VIG_ADR_ROW_BIT), {lcg() >> 8, g}, d);
      if (row && idx < `VIG_NUM_ROWS) m_row[idx] = g;
      else if (!row) m_col[idx] = g;
   endtask

   task automatic read_check(logic row, int idx);
      logic [31:0] d;
      logic [31:0] e;
      wb_access(1'b0, 12'(idx) | (12'(row) << `VIG_ADR_ROW_BIT), 32'h0, d);
      e = row ? ((idx < `VIG_NUM_ROWS) ? m_row[idx] : 32'h0) : m_col[idx];
      check("wb_rsp.dat", d, e);
   endtask

   // Drives one beat and checks the beat sent two cycles earlier
   task automatic step(vig_pkg::pix_beat_t b);
      vig_pkg::pix_beat_t e;
      logic [31:0]        prod;
      int                 rg;
      @(negedge clk);
      if (exp_q.size() == 2) check("beat_out", beat_out, exp_q.pop_front());
      beat_in = b;
      e = b;
      if (b.valid && enable && b.btype == vig_pkg::BT_PIXEL) begin
         rg   = (row_pos < `VIG_NUM_ROWS) ? m_row[row_pos] : 0;
         prod = (b.data[7:0] * m_col[col_pos] * rg) >> 12;   // Two 2.6 gains
         e.data = (prod > 255) ? 16'd255 : {8'h00, prod[7:0]};
      end
      if (b.valid) begin
         case (b.btype)
            vig_pkg::BT_ROW_START:   col_pos = 0;
            vig_pkg::BT_PIXEL:       col_pos++;
            vig_pkg::BT_FRAME_START: row_pos = 0;
            vig_pkg::BT_ROW_END:     row_pos++;
            default: ;
         endcase
      end
      exp_q.push_back(e);
   endtask

   task automatic flush();
      step('0);
      step('0);
      exp_q.delete();   // Only idle beats left
   endtask

   task automatic send_frame(int ncols, int nrows, logic vary, logic bright);
      logic [31:0] r;
      int          n;
      step(make_beat(1'b1, vig_pkg::BT_FRAME_START, lcg()));
      for (int row = 0; row < nrows; row++) begin
         n = vary ? 1 + rnd(ncols) : ncols;   // Short rows test the row start reset
         step(make_beat(1'b1, vig_pkg::BT_ROW_START, lcg()));
         for (int c = 0; c < n; c++) begin
            r = lcg();
            step(make_beat(1'b1, vig_pkg::BT_PIXEL, r[23:8] | (bright ? 16'h00c0 : 16'h0)));
            if (rnd(8) == 0) step(make_beat(1'b1, vig_pkg::BT_AUX, lcg()));
            if (rnd(8) == 0) step(make_beat(1'b0, vig_pkg::beat_type_e'(rnd(6)), lcg()));
         end
         step(make_beat(1'b1, vig_pkg::BT_ROW_END, lcg()));
      end
      step(make_beat(1'b1, vig_pkg::BT_FRAME_END, lcg()));
   endtask

   initial begin
      int   idx;
      logic row;
      clk = 1'b0;
      resetb = 1'b0;
      enable = 1'b1;
      wb_req = '0;
      beat_in = '0;
      seed = 32'hce6cab81;
      foreach (m_col[i]) m_col[i] = 8'd`VIG_GAIN_ONE;
      foreach (m_row[i]) m_row[i] = 8'd`VIG_GAIN_ONE;
      repeat (8) @(posedge clk);
      @(negedge clk) resetb = 1'b1;

      check("beat_out.valid", beat_out.valid, 0);
      check("wb_rsp.ack", wb_rsp.ack, 0);
      for (int i = 0; i < `VIG_NUM_COLS; i++) read_check(1'b0, i);
      for (int i = 0; i < `VIG_NUM_ROWS; i++) read_check(1'b1, i);
      send_frame(16, 8, 1'b0, 1'b0);
      flush();
      end_test("reset_defaults");

      repeat (24) begin
         row = rnd(2);
         idx = rnd(row ? `VIG_NUM_ROWS : `VIG_NUM_COLS);
         write_gain(row, idx, lcg());
         read_check(row, idx);
      end
      write_gain(1'b1, 40, 8'ha5);   // Past the row table
      read_check(1'b1, 40);
      read_check(1'b1, 40 % `VIG_NUM_ROWS);   // Entry sharing the low index bits
      end_test("host_access");

      for (int i = 0; i < `VIG_NUM_COLS; i++) write_gain(1'b0, i, rnd(192));
      for (int i = 0; i < `VIG_NUM_ROWS; i++) write_gain(1'b1, i, rnd(192));
      repeat (3) send_frame(1 + rnd(64), 1 + rnd(32), 1'b1, 1'b0);
      flush();
      end_test("random_correction");

      for (int i = 0; i < 8; i++) write_gain(1'b0, i, 8'd255);
      for (int i = 0; i < 2; i++) write_gain(1'b1, i, 8'd255);
      send_frame(8, 2, 1'b0, 1'b1);
      flush();
      for (int i = 0; i < 8; i++) write_gain(1'b0, i, 8'd0);
      send_frame(8, 2, 1'b0, 1'b1);
      flush();
      end_test("clamp");

      enable = 1'b0;
      send_frame(32, 16, 1'b1, 1'b0);
      flush();
      enable = 1'b1;
      end_test("bypass");

      // Gains differ per column and per row
      for (int i = 0; i < `VIG_NUM_COLS; i++) write_gain(1'b0, i, 32 + i);
      for (int i = 0; i < `VIG_NUM_ROWS; i++) write_gain(1'b1, i, 40 + 2 * i);
      send_frame(64, 12, 1'b1, 1'b0);
      send_frame(20, 5, 1'b1, 1'b0);
      flush();
      for (int i = 0; i < `VIG_NUM_COLS; i++) write_gain(1'b0, i, 100 - i);
      for (int i = 0; i < `VIG_NUM_ROWS; i++) write_gain(1'b1, i, 90 - i);
      send_frame(40, 6, 1'b1, 1'b0);
      flush();
      end_test("position_tracking");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests, failed_tests, checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule
